// File: include/usb_hid_regs.svh
// ############################################################
// word addresses are 3 bits; counters are 8 bits per port
// ############################################################

`ifndef usb_hid_regs_svh
`define usb_hid_regs_svh

`define usb_hid_adr_p0_lo    3'd0
`define usb_hid_adr_p0_hi    3'd1
`define usb_hid_adr_p1_lo    3'd2
`define usb_hid_adr_p1_hi    3'd3
`define usb_hid_adr_p2_lo    3'd4
`define usb_hid_adr_p2_hi    3'd5
`define usb_hid_adr_status   3'd6
`define usb_hid_adr_control  3'd7

// status word: counter of port n at bits n*8 +: 8
`define usb_hid_stat_cnt_bits 8
`define usb_hid_stat_err_lsb  24

// control word
`define usb_hid_ctl_en_lsb    0
`define usb_hid_ctl_clr_bit   8  // write-only, reads zero

`endif

// File: verilog/usb_hid_pkg.sv
// ############################################################
// port count and prefix size are fixed; register numbers
// come from usb_hid_regs.svh, so the include path must be set
// ############################################################

`include "usb_hid_regs.svh"

package usb_hid_pkg;

  // host ports feeding the capture block
  localparam int num_ports = 3;

  // leading report bytes kept per port, 64 bits
  localparam int prefix_bytes = 8;

  // per-port report assembler
  typedef enum logic [1:0]
  {
    asm_idle,    // waiting for the first byte
    asm_collect, // inside a report
    asm_discard  // too long, drop until last
  } asm_state_t;

  // word select on the wishbone side
  typedef enum logic [2:0]
  {
    reg_p0_lo   = `usb_hid_adr_p0_lo,
    reg_p0_hi   = `usb_hid_adr_p0_hi,
    reg_p1_lo   = `usb_hid_adr_p1_lo,
    reg_p1_hi   = `usb_hid_adr_p1_hi,
    reg_p2_lo   = `usb_hid_adr_p2_lo,
    reg_p2_hi   = `usb_hid_adr_p2_hi,
    reg_status  = `usb_hid_adr_status,  // counters and error flags
    reg_control = `usb_hid_adr_control  // enable mask, clear strobe
  } reg_sel_t;

endpackage

// File: verilog/hid_report_assembler.sv
// ############################################################
// no back-pressure, every valid byte is taken; reports longer
// than 255 bytes are dropped and flagged as length errors
// ############################################################

module hid_report_assembler
#(
  parameter int report_bytes  = 20,   // expected report length
  parameter bit strict_length = 1'b1  // 0: any length of one byte or more
)
(
  input  logic                                    clk_usb,
  input  logic                                    arst_n,
  input  logic                                    byte_valid,
  input  logic                                    byte_last,
  input  logic [7:0]                              byte_data,
  output logic                                    rpt_valid,
  output logic                                    rpt_len_err,
  output logic [usb_hid_pkg::prefix_bytes*8-1:0]  rpt_prefix
);

  import usb_hid_pkg::*;

  localparam int prefix_w = prefix_bytes * 8;
  localparam int idx_w    = $clog2(prefix_bytes);

  asm_state_t          state;
  logic [7:0]          byte_cnt;     // bytes already taken in this report
  logic [prefix_w-1:0] work_prefix;  // prefix under construction
  logic [prefix_w-1:0] work_next;
  logic                cnt_full;
  logic                len_ok;
  logic                end_ok;
  logic                end_bad;

  // prefix including the byte on the inputs now
  always_comb
  begin
    work_next = work_prefix;
    if (state == asm_idle)
    begin
      work_next       = '0;  // missing bytes read as zero
      work_next[7:0]  = byte_data;
    end
    else if (byte_cnt < prefix_bytes)
    begin
      work_next[byte_cnt[idx_w-1:0]*8 +: 8] = byte_data;
    end
  end

  assign cnt_full = (byte_cnt == 8'hff);  // next byte would be the 256th
  assign len_ok   = !strict_length || (int'(byte_cnt) + 1 == report_bytes);

  // judge the report on its last byte
  assign end_ok  = byte_valid && byte_last && (state != asm_discard) && !cnt_full && len_ok;
  assign end_bad = byte_valid && byte_last && !end_ok;

  always_ff @(posedge clk_usb or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state       <= asm_idle;
      byte_cnt    <= '0;
      rpt_valid   <= 1'b0;
      rpt_len_err <= 1'b0;
    end
    else
    begin
      rpt_valid   <= end_ok;   // one-cycle pulses
      rpt_len_err <= end_bad;
      case (state)
        asm_idle:
        begin
          if (byte_valid && !byte_last)
          begin
            state    <= asm_collect;
            byte_cnt <= 8'd1;
          end
        end
        asm_collect:
        begin
          if (byte_valid)
          begin
            if (byte_last)
            begin
              state    <= asm_idle;
              byte_cnt <= '0;
            end
            else if (cnt_full)
              state <= asm_discard;
            else
              byte_cnt <= byte_cnt + 8'd1;
          end
        end
        asm_discard:
        begin
          if (byte_valid && byte_last)
          begin
            state    <= asm_idle;
            byte_cnt <= '0;
          end
        end
        default:
        begin
          state    <= asm_idle;
          byte_cnt <= '0;
        end
      endcase
    end
  end

  // output prefix only moves on a good report
  always_ff @(posedge clk_usb)
  begin
    if (byte_valid)
      work_prefix <= work_next;
    if (end_ok)
      rpt_prefix <= work_next;
  end

endmodule

// File: verilog/report_display_bank.sv
// ############################################################
// counters wrap at 256; error flags stay set until cleared;
// events from disabled ports are ignored
// ############################################################

module report_display_bank
(
  input  logic                                                       clk_usb,
  input  logic                                                       arst_n,
  input  logic [usb_hid_pkg::num_ports-1:0]                          rpt_valid,
  input  logic [usb_hid_pkg::num_ports-1:0]                          rpt_len_err,
  input  logic [usb_hid_pkg::num_ports*usb_hid_pkg::prefix_bytes*8-1:0] rpt_prefix,
  input  logic [usb_hid_pkg::num_ports-1:0]                          port_enable,
  input  logic                                                       cnt_clear,
  output logic [2*usb_hid_pkg::num_ports-1:0][31:0]                  disp_words,
  output logic [usb_hid_pkg::num_ports-1:0][7:0]                     upd_count,
  output logic [usb_hid_pkg::num_ports-1:0]                          err_flags
);

  import usb_hid_pkg::*;

  localparam int prefix_w = prefix_bytes * 8;

  for (genvar p = 0; p < num_ports; p++)
  begin : g_port
    logic take_rpt;
    logic take_err;

    assign take_rpt = rpt_valid[p] && port_enable[p];
    assign take_err = rpt_len_err[p] && port_enable[p];

    // display words, low word holds bytes 0..3
    always_ff @(posedge clk_usb or negedge arst_n)
    begin
      if (!arst_n)
      begin
        disp_words[2*p]   <= '0;
        disp_words[2*p+1] <= '0;
      end
      else if (take_rpt)
      begin
        disp_words[2*p]   <= rpt_prefix[p*prefix_w +: 32];
        disp_words[2*p+1] <= rpt_prefix[p*prefix_w+32 +: 32];
      end
    end

    always_ff @(posedge clk_usb or negedge arst_n)
    begin
      if (!arst_n)
      begin
        upd_count[p] <= '0;
        err_flags[p] <= 1'b0;
      end
      else if (cnt_clear)  // clear beats a same-cycle update
      begin
        upd_count[p] <= '0;
        err_flags[p] <= 1'b0;
      end
      else
      begin
        if (take_rpt)
          upd_count[p] <= upd_count[p] + 8'd1;  // wraps
        if (take_err)
          err_flags[p] <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/wb_report_regs.sv
// ############################################################
// wishbone classic, ack one cycle after the request; only the
// control word is writable, other writes are acked and dropped
// ############################################################

`include "usb_hid_regs.svh"

module wb_report_regs
(
  input  logic                                       clk_usb,
  input  logic                                       arst_n,
  input  logic                                       wb_cyc,
  input  logic                                       wb_stb,
  input  logic                                       wb_we,
  input  logic [2:0]                                 wb_adr,
  input  logic [31:0]                                wb_dat_w,
  output logic [31:0]                                wb_dat_r,
  output logic                                       wb_ack,
  input  logic [2*usb_hid_pkg::num_ports-1:0][31:0]  disp_words,
  input  logic [usb_hid_pkg::num_ports-1:0][7:0]     upd_count,
  input  logic [usb_hid_pkg::num_ports-1:0]          err_flags,
  output logic [usb_hid_pkg::num_ports-1:0]          port_enable,
  output logic                                       cnt_clear
);

  import usb_hid_pkg::*;

  reg_sel_t    sel;
  logic        req;
  logic        wr_ctl;
  logic [31:0] rd_data;

  assign sel = reg_sel_t'(wb_adr);

  // new request only, stb is still high in the ack cycle
  assign req    = wb_cyc && wb_stb && !wb_ack;
  assign wr_ctl = req && wb_we && (sel == reg_control);

  // read mux, unused bits stay zero
  always_comb
  begin
    rd_data = '0;
    case (sel)
      reg_p0_lo, reg_p0_hi, reg_p1_lo, reg_p1_hi, reg_p2_lo, reg_p2_hi:
        rd_data = disp_words[wb_adr];
      reg_status:
      begin
        for (int p = 0; p < num_ports; p++)
          rd_data[p*`usb_hid_stat_cnt_bits +: 8] = upd_count[p];
        rd_data[`usb_hid_stat_err_lsb +: num_ports] = err_flags;
      end
      reg_control:
        rd_data[`usb_hid_ctl_en_lsb +: num_ports] = port_enable;  // clear bit reads 0
      default:
        rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_usb or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wb_ack      <= 1'b0;
      port_enable <= '1;  // all ports live out of reset
      cnt_clear   <= 1'b0;
    end
    else
    begin
      wb_ack    <= req;
      cnt_clear <= wr_ctl && wb_dat_w[`usb_hid_ctl_clr_bit];  // single pulse
      if (wr_ctl)
        port_enable <= wb_dat_w[`usb_hid_ctl_en_lsb +: num_ports];
    end
  end

  // read data is sampled with the request
  always_ff @(posedge clk_usb)
  begin
    if (req)
      wb_dat_r <= rd_data;
  end

endmodule

// File: verilog/usb_hid_capture_top.sv
// ############################################################
// host cores sit outside; one byte stream per port, 2-cycle
// latency from last byte to the register bank
// ############################################################

module usb_hid_capture_top
#(
  parameter int report_bytes  = 20,
  parameter bit strict_length = 1'b1
)
(
  input  logic                                clk_usb,
  input  logic                                arst_n,
  input  logic [usb_hid_pkg::num_ports-1:0]   hid_byte_valid,
  input  logic [usb_hid_pkg::num_ports*8-1:0] hid_byte_data,  // 8-bit slice per port
  input  logic [usb_hid_pkg::num_ports-1:0]   hid_byte_last,
  input  logic                                wb_cyc,
  input  logic                                wb_stb,
  input  logic                                wb_we,
  input  logic [2:0]                          wb_adr,
  input  logic [31:0]                         wb_dat_w,
  output logic [31:0]                         wb_dat_r,
  output logic                                wb_ack
);

  import usb_hid_pkg::*;

  logic [num_ports-1:0]                rpt_valid;
  logic [num_ports-1:0]                rpt_len_err;
  logic [num_ports*prefix_bytes*8-1:0] rpt_prefix;
  logic [2*num_ports-1:0][31:0]        disp_words;
  logic [num_ports-1:0][7:0]           upd_count;
  logic [num_ports-1:0]                err_flags;
  logic [num_ports-1:0]                port_enable;
  logic                                cnt_clear;

  for (genvar p = 0; p < num_ports; p++)
  begin : g_asm
    hid_report_assembler
    #(
      .report_bytes  (report_bytes),
      .strict_length (strict_length)
    )
    asm_i
    (
      .clk_usb     (clk_usb),
      .arst_n      (arst_n),
      .byte_valid  (hid_byte_valid[p]),
      .byte_last   (hid_byte_last[p]),
      .byte_data   (hid_byte_data[p*8 +: 8]),
      .rpt_valid   (rpt_valid[p]),
      .rpt_len_err (rpt_len_err[p]),
      .rpt_prefix  (rpt_prefix[p*prefix_bytes*8 +: prefix_bytes*8])
    );
  end

  report_display_bank bank_i
  (
    .clk_usb     (clk_usb),
    .arst_n      (arst_n),
    .rpt_valid   (rpt_valid),
    .rpt_len_err (rpt_len_err),
    .rpt_prefix  (rpt_prefix),
    .port_enable (port_enable),
    .cnt_clear   (cnt_clear),
    .disp_words  (disp_words),
    .upd_count   (upd_count),
    .err_flags   (err_flags)
  );

  wb_report_regs regs_i
  (
    .clk_usb     (clk_usb),
    .arst_n      (arst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .disp_words  (disp_words),
    .upd_count   (upd_count),
    .err_flags   (err_flags),
    .port_enable (port_enable),
    .cnt_clear   (cnt_clear)
  );

endmodule

// File: sim/usb_hid_capture_asserts.sv
// ############################################################
// bound into wb_report_regs, watches the slave side only
// ############################################################

module usb_hid_capture_asserts
(
  input logic clk_usb,
  input logic arst_n,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic cnt_clear
);

  // ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk_usb) disable iff (!arst_n)
    wb_ack |=> !wb_ack)
    else $error("wb_ack stayed high for more than one cycle");

  ack_after_req: assert property (@(posedge clk_usb) disable iff (!arst_n)
    wb_ack |-> $past(wb_cyc && wb_stb))  // no ack without a request
    else $error("wb_ack rose without a request in the cycle before");

  // clear strobe from the control write
  clear_one_cycle: assert property (@(posedge clk_usb) disable iff (!arst_n)
    cnt_clear |=> !cnt_clear)
    else $error("cnt_clear stayed high for more than one cycle");

endmodule

bind wb_report_regs usb_hid_capture_asserts asserts_i
(
  .clk_usb   (clk_usb),
  .arst_n    (arst_n),
  .wb_cyc    (wb_cyc),
  .wb_stb    (wb_stb),
  .wb_ack    (wb_ack),
  .cnt_clear (cnt_clear)
);

// File: sim/tb_usb_hid_capture.sv
// ############################################################
// strict length with 20-byte reports; all reads go through
// the wishbone slave, stimulus from a fixed xorshift seed
// ############################################################

`include "usb_hid_regs.svh"

module tb_usb_hid_capture;

  import usb_hid_pkg::*;

  localparam int report_bytes = 20;
  localparam int clk_period   = 100;
  localparam int max_len      = 30;
  localparam int n_random     = 40;
  localparam int n_disable    = 6;
  localparam int n_wrap       = 260;
  // one group is a send plus the register reads after it
  localparam int n_groups      = n_random + num_ports + n_disable + n_wrap + 8;
  localparam int group_cycles  = 2 * max_len + 8 + 60;
  localparam int watchdog_time = (n_groups * group_cycles + 400) * clk_period;

  logic                   clk_usb;
  logic                   arst_n;
  logic [num_ports-1:0]   hid_byte_valid;
  logic [num_ports*8-1:0] hid_byte_data;
  logic [num_ports-1:0]   hid_byte_last;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [2:0]             wb_adr;
  logic [31:0]            wb_dat_w;
  logic [31:0]            wb_dat_r;
  logic                   wb_ack;

  logic [31:0]          rng_state;
  logic [7:0]           rpt_buf [num_ports][32];  // report waiting to be sent
  int                   rpt_len [num_ports];
  logic [63:0]          exp_prefix [num_ports];   // model state
  logic [7:0]           exp_cnt [num_ports];
  logic [num_ports-1:0] exp_err;
  logic [num_ports-1:0] exp_en;
  int                   errors;
  int                   test_errors;
  int                   tests_passed;
  int                   tests_failed;

  usb_hid_capture_top
  #(
    .report_bytes  (report_bytes),
    .strict_length (1'b1)
  )
  dut_i
  (
    .clk_usb        (clk_usb),
    .arst_n         (arst_n),
    .hid_byte_valid (hid_byte_valid),
    .hid_byte_data  (hid_byte_data),
    .hid_byte_last  (hid_byte_last),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack)
  );

  initial
  begin
    clk_usb = 1'b0;
    forever #(clk_period / 2) clk_usb = ~clk_usb;
  end

  initial
  begin
    #(watchdog_time);
    $display("watchdog expired at %0t, the run did not finish", $time);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int next_rand(input int n);
    rng_state = xorshift(rng_state);
    return int'(rng_state % 32'(n));
  endfunction

  function automatic int pick_bad_length();
    int len;
    len = report_bytes;
    while (len == report_bytes)
      len = 3 + next_rand(max_len - 2);  // 3 to 30
    return len;
  endfunction

  function automatic logic [2:0] word_adr(input int p, input bit hi);
    logic [2:0] a;
    case (p)
      0: a = hi ? `usb_hid_adr_p0_hi : `usb_hid_adr_p0_lo;
      1: a = hi ? `usb_hid_adr_p1_hi : `usb_hid_adr_p1_lo;
      default: a = hi ? `usb_hid_adr_p2_hi : `usb_hid_adr_p2_lo;
    endcase
    return a;
  endfunction

  function automatic logic [31:0] expected_status();
    logic [31:0] v;
    v = '0;
    for (int p = 0; p < num_ports; p++)
    begin
      v[p*`usb_hid_stat_cnt_bits +: 8] = exp_cnt[p];
      v[`usb_hid_stat_err_lsb + p]     = exp_err[p];
    end
    return v;
  endfunction

  function automatic logic [31:0] ctl_word(input logic [2:0] en, input bit clr);
    logic [31:0] v;
    v = '0;
    v[`usb_hid_ctl_en_lsb +: num_ports] = en;
    v[`usb_hid_ctl_clr_bit]             = clr;
    return v;
  endfunction

  task automatic fill_report(input int p, input int len);
    rpt_len[p] = len;
    for (int i = 0; i < len; i++)
      rpt_buf[p][i] = 8'(next_rand(256));
  endtask

  // only a good-length report on an enabled port moves the words
  task automatic model_apply(input int p);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < prefix_bytes && i < rpt_len[p]; i++)
      v[i*8 +: 8] = rpt_buf[p][i];
    if (exp_en[p] && rpt_len[p] == report_bytes)
    begin
      exp_prefix[p] = v;
      exp_cnt[p]    = exp_cnt[p] + 8'd1;
    end
    else if (exp_en[p])
      exp_err[p] = 1'b1;
  endtask

  // streams run side by side, with random idle cycles
  task automatic send_reports(input logic [2:0] mask);
    int         pos [num_ports];
    int         gap [num_ports];
    logic [2:0] active;
    active = mask;
    for (int p = 0; p < num_ports; p++)
    begin
      pos[p] = 0;
      gap[p] = next_rand(4);
    end
    while (active != 3'b000)
    begin
      @(negedge clk_usb);
      for (int p = 0; p < num_ports; p++)
      begin
        hid_byte_valid[p] = 1'b0;
        hid_byte_last[p]  = 1'b0;
        if (active[p] && gap[p] > 0)
          gap[p]--;
        else if (active[p])
        begin
          hid_byte_valid[p]       = 1'b1;
          hid_byte_data[p*8 +: 8] = rpt_buf[p][pos[p]];
          hid_byte_last[p]        = (pos[p] == rpt_len[p] - 1);
          pos[p]++;
          if (pos[p] == rpt_len[p])
            active[p] = 1'b0;
          else
            gap[p] = (next_rand(4) == 0) ? 1 : 0;
        end
      end
    end
    @(negedge clk_usb);
    hid_byte_valid = '0;
    hid_byte_last  = '0;
    for (int p = 0; p < num_ports; p++)
      if (mask[p])
        model_apply(p);
    repeat (2) @(negedge clk_usb);  // last byte to register latency
  endtask

  task automatic wait_ack(input string what);
    int n;
    n = 0;
    @(negedge clk_usb);
    while (!wb_ack && n < 16)
    begin
      n++;
      @(negedge clk_usb);
    end
    if (!wb_ack)
    begin
      $display("bus %s got no ack within 16 cycles", what);
      errors++;
      test_errors++;
    end
  endtask

  task automatic read_reg(input logic [2:0] adr, output logic [31:0] data);
    @(negedge clk_usb);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack("read");
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic write_reg(input logic [2:0] adr, input logic [31:0] data);
    @(negedge clk_usb);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wait_ack("write");
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic check_reg(input string test, input logic [2:0] adr, input logic [31:0] exp);
    logic [31:0] got;
    read_reg(adr, got);
    if (got !== exp)
    begin
      $display("Error: %s reg %0d expected %08h actual %08h", test, adr, exp, got);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_port(input string test, input int p);
    check_reg(test, word_adr(p, 1'b0), exp_prefix[p][31:0]);
    check_reg(test, word_adr(p, 1'b1), exp_prefix[p][63:32]);
    check_reg(test, `usb_hid_adr_status, expected_status());
  endtask

  task automatic finish_test(input string test);
    if (test_errors == 0)
    begin
      tests_passed++;
      $display("test %s passed", test);
    end
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d errors", test, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic reset_values();
    for (int a = 0; a < 7; a++)
      check_reg("reset_values", 3'(a), 32'h0);
    check_reg("reset_values", `usb_hid_adr_control, ctl_word(3'b111, 1'b0));
    finish_test("reset_values");
  endtask

  task automatic random_reports();
    logic [2:0] mask;
    for (int r = 0; r < n_random; r++)
    begin
      mask = 3'b001 << next_rand(num_ports);
      if (next_rand(4) == 0)
        mask = 3'(1 + next_rand(7));  // overlapping ports
      for (int p = 0; p < num_ports; p++)
        if (mask[p])
          fill_report(p, report_bytes);
      send_reports(mask);
      for (int p = 0; p < num_ports; p++)
        if (mask[p])
          check_port("random_reports", p);
    end
    finish_test("random_reports");
  endtask

  task automatic wrong_length();
    for (int p = 0; p < num_ports; p++)
    begin
      fill_report(p, pick_bad_length());
      send_reports(3'b001 << p);
      check_port("wrong_length", p);  // flag is in the status word
    end
    finish_test("wrong_length");
  endtask

  task automatic port_disable();
    int         dis;
    logic [2:0] en;
    dis = next_rand(num_ports);
    en  = 3'b111 & ~(3'b001 << dis);
    write_reg(`usb_hid_adr_control, ctl_word(en, 1'b1));  // flags start low
    exp_en  = en;
    exp_err = '0;
    for (int p = 0; p < num_ports; p++)
      exp_cnt[p] = 8'd0;
    check_reg("port_disable", `usb_hid_adr_control, ctl_word(en, 1'b0));
    for (int r = 0; r < n_disable; r++)
    begin
      for (int p = 0; p < num_ports; p++)
        fill_report(p, (r == 0) ? pick_bad_length() : report_bytes);
      send_reports(3'b111);
      for (int p = 0; p < num_ports; p++)
        check_port("port_disable", p);
    end
    write_reg(`usb_hid_adr_control, ctl_word(3'b111, 1'b0));
    exp_en = 3'b111;
    finish_test("port_disable");
  endtask

  task automatic clear_and_wrap();
    int wp;
    write_reg(`usb_hid_adr_control, ctl_word(3'b111, 1'b1));
    for (int p = 0; p < num_ports; p++)
      exp_cnt[p] = 8'd0;
    exp_err = '0;
    check_reg("clear_and_wrap", `usb_hid_adr_status, expected_status());
    for (int p = 0; p < num_ports; p++)
    begin
      check_reg("clear_and_wrap", word_adr(p, 1'b0), exp_prefix[p][31:0]);
      check_reg("clear_and_wrap", word_adr(p, 1'b1), exp_prefix[p][63:32]);
    end
    wp = next_rand(num_ports);
    for (int i = 0; i < n_wrap; i++)
    begin
      fill_report(wp, report_bytes);
      send_reports(3'b001 << wp);
      if (i == 255)
        check_reg("clear_and_wrap", `usb_hid_adr_status, expected_status());  // back at zero
    end
    check_port("clear_and_wrap", wp);
    finish_test("clear_and_wrap");
  endtask

  initial
  begin
    arst_n         = 1'b0;
    hid_byte_valid = '0;
    hid_byte_data  = '0;
    hid_byte_last  = '0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = 3'd0;
    wb_dat_w       = 32'h0;
    rng_state      = 32'h8cf;
    errors         = 0;
    test_errors    = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    exp_err        = '0;
    exp_en         = '1;
    for (int p = 0; p < num_ports; p++)
    begin
      exp_prefix[p] = 64'h0;
      exp_cnt[p]    = 8'd0;
      rpt_len[p]    = 0;
    end
    repeat (16) @(posedge clk_usb);
    @(negedge clk_usb);
    arst_n = 1'b1;

    reset_values();
    random_reports();
    wrong_length();
    port_disable();
    clear_and_wrap();

    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
verilog/usb_hid_pkg.sv
verilog/hid_report_assembler.sv
verilog/report_display_bank.sv
verilog/wb_report_regs.sv
verilog/usb_hid_capture_top.sv
sim/usb_hid_capture_asserts.sv
sim/tb_usb_hid_capture.sv

// File: run_sim.sh
#!/bin/sh
# build the capture testbench with Verilator, run it, then scan the log
rm -rf obj_dir build.log sim.log
verilator --binary --assert -Wno-fatal --top-module tb_usb_hid_capture \
  -f verilog.f -o tb_usb_hid_capture > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/tb_usb_hid_capture > sim.log 2>&1 \
  || echo "simulator exited with an error status"
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST OK" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"
